/* logic/warblade_pkg.sv */
/*
 * shared types and constants of the pixel path:
 * coordinate and colour vectors, sprite sizes, movement steps,
 * palette and the missile state encoding
 */

package warblade_pkg;

  // pixel coordinates and counters
  typedef logic [10:0] coord_t;

  // 4 bits each of red, green, blue
  typedef logic [11:0] rgb_t;

  // palette
  localparam rgb_t BG_COLOR      = 12'h113;
  localparam rgb_t BORDER_COLOR  = 12'hfff;
  localparam rgb_t SHIP_COLOR    = 12'h0f0;
  localparam rgb_t MISSILE_COLOR = 12'hf80;

  // ship rectangle
  localparam coord_t SHIP_W = 11'd8;
  localparam coord_t SHIP_H = 11'd4;

  // missile is a single column of this height
  localparam coord_t MISSILE_H = 11'd3;

  // per-frame movement
  localparam coord_t SHIP_STEP    = 11'd2;
  localparam coord_t MISSILE_STEP = 11'd4;

  typedef enum logic {
    MS_IDLE,
    MS_FLYING
  } missile_state_t;

endpackage

/* logic/vga_if.sv */
/*
 * pixel stream between the drawing stages:
 * counters, sync and blanking levels, colour
 */

`timescale 1ns/1ps

interface vga_if import warblade_pkg::*; ();

  coord_t hcount;
  coord_t vcount;
  logic   hsync;
  logic   vsync;
  logic   hblnk;
  logic   vblnk;
  rgb_t   rgb;

  modport source (
    output hcount, vcount,
    output hsync, vsync,
    output hblnk, vblnk,
    output rgb
  );

  modport sink (
    input hcount, vcount,
    input hsync, vsync,
    input hblnk, vblnk,
    input rgb
  );

endinterface

/* logic/ship_if.sv */
/*
 * ship and missile position, control block to drawing stage
 */

`timescale 1ns/1ps

interface ship_if import warblade_pkg::*; ();

  coord_t ship_x;
  coord_t missile_x;
  coord_t missile_y;
  logic   missile_on;

  modport source (output ship_x, missile_x, missile_y, missile_on);

  modport sink (input ship_x, missile_x, missile_y, missile_on);

endinterface

/* logic/vga_timing.sv */
/*
 * horizontal and vertical counters with sync and blanking,
 * first stage of the pixel stream
 */

`timescale 1ns/1ps

module vga_timing import warblade_pkg::*; #(
  parameter int H_ACTIVE = 64,
  parameter int H_FP     = 4,
  parameter int H_SYNC   = 8,
  parameter int H_BP     = 4,
  parameter int V_ACTIVE = 48,
  parameter int V_FP     = 2,
  parameter int V_SYNC   = 2,
  parameter int V_BP     = 2
) (
  input  logic pclk,
  input  logic arst_n_i,
  vga_if.source vga_o
);

  localparam int H_TOTAL = H_ACTIVE + H_FP + H_SYNC + H_BP;
  localparam int V_TOTAL = V_ACTIVE + V_FP + V_SYNC + V_BP;
  localparam coord_t H_LAST = coord_t'(H_TOTAL - 1);
  localparam coord_t V_LAST = coord_t'(V_TOTAL - 1);

  coord_t hcount_nxt;
  coord_t vcount_nxt;

  // next counter pair, sync and blanking are derived from it
  // so that all fields leave the register together
  always_comb begin
    hcount_nxt = vga_o.hcount + 11'd1;
    vcount_nxt = vga_o.vcount;
    if (vga_o.hcount == H_LAST) begin
      hcount_nxt = '0;
      if (vga_o.vcount == V_LAST) begin
        vcount_nxt = '0;
      end else begin
        vcount_nxt = vga_o.vcount + 11'd1;
      end
    end
  end

  always_ff @(posedge pclk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      vga_o.hcount <= '0;
      vga_o.vcount <= '0;
      vga_o.hblnk  <= 1'b0;
      vga_o.vblnk  <= 1'b0;
      vga_o.hsync  <= 1'b0;
      vga_o.vsync  <= 1'b0;
    end else begin
      vga_o.hcount <= hcount_nxt;
      vga_o.vcount <= vcount_nxt;
      vga_o.hblnk  <= (hcount_nxt >= H_ACTIVE);
      vga_o.vblnk  <= (vcount_nxt >= V_ACTIVE);
      vga_o.hsync  <= (hcount_nxt >= H_ACTIVE + H_FP) &&
                      (hcount_nxt <  H_ACTIVE + H_FP + H_SYNC);
      vga_o.vsync  <= (vcount_nxt >= V_ACTIVE + V_FP) &&
                      (vcount_nxt <  V_ACTIVE + V_FP + V_SYNC);
    end
  end

  // no colour yet, later stages paint
  assign vga_o.rgb = '0;

  a_hcount_range: assert property (@(posedge pclk) disable iff (!arst_n_i)
    vga_o.hcount <= H_LAST);

  a_hsync_blank: assert property (@(posedge pclk) disable iff (!arst_n_i)
    (vga_o.hcount < H_ACTIVE) |-> !vga_o.hsync);

endmodule

/* logic/draw_background.sv */
/*
 * background stage: fill colour with a one pixel border
 */

`timescale 1ns/1ps

module draw_background import warblade_pkg::*; #(
  parameter int H_ACTIVE = 64,
  parameter int V_ACTIVE = 48
) (
  input  logic pclk,
  input  logic arst_n_i,
  vga_if.sink   vga_i,
  vga_if.source vga_o
);

  logic on_border;
  rgb_t rgb_nxt;

  assign on_border = (vga_i.hcount == '0) || (vga_i.hcount == H_ACTIVE - 1) ||
                     (vga_i.vcount == '0) || (vga_i.vcount == V_ACTIVE - 1);

  always_comb begin
    if (vga_i.hblnk || vga_i.vblnk) begin
      rgb_nxt = '0;
    end else if (on_border) begin
      rgb_nxt = BORDER_COLOR;
    end else begin
      rgb_nxt = BG_COLOR;
    end
  end

  always_ff @(posedge pclk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      vga_o.hcount <= '0;
      vga_o.vcount <= '0;
      vga_o.hsync  <= 1'b0;
      vga_o.vsync  <= 1'b0;
      vga_o.hblnk  <= 1'b0;
      vga_o.vblnk  <= 1'b0;
      vga_o.rgb    <= '0;
    end else begin
      vga_o.hcount <= vga_i.hcount;
      vga_o.vcount <= vga_i.vcount;
      vga_o.hsync  <= vga_i.hsync;
      vga_o.vsync  <= vga_i.vsync;
      vga_o.hblnk  <= vga_i.hblnk;
      vga_o.vblnk  <= vga_i.vblnk;
      vga_o.rgb    <= rgb_nxt;
    end
  end

endmodule

/* logic/delay.sv */
/*
 * register chain of configurable width and depth
 */

`timescale 1ns/1ps

module delay #(
  parameter int WIDTH   = 1,
  parameter int CLK_DEL = 1
) (
  input  logic             pclk,
  input  logic             arst_n_i,
  input  logic [WIDTH-1:0] din_i,
  output logic [WIDTH-1:0] dout_o
);

  logic [WIDTH-1:0] stage_q [CLK_DEL];

  always_ff @(posedge pclk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < CLK_DEL; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= din_i;
      for (int i = 1; i < CLK_DEL; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign dout_o = stage_q[CLK_DEL-1];

endmodule

/* logic/ship_control.sv */
/*
 * ship position and missile FSM, updated once per frame
 * at the start of vertical blanking
 */

`timescale 1ns/1ps

module ship_control import warblade_pkg::*; #(
  parameter int H_ACTIVE    = 64,
  parameter int V_ACTIVE    = 48,
  parameter int RESET_X_POS = 20
) (
  input  logic pclk,
  input  logic arst_n_i,
  input  logic left_i,
  input  logic right_i,
  input  logic shoot_i,
  vga_if.sink     vga_i,
  ship_if.source  ship_o
);

  localparam coord_t SHIP_Y = coord_t'(V_ACTIVE - SHIP_H - 2);
  localparam coord_t X_MAX  = coord_t'(H_ACTIVE - SHIP_W);

  logic           frame_stb;
  logic           launch;
  coord_t         ship_x_q;
  coord_t         ship_x_nxt;
  coord_t         missile_x_q;
  coord_t         missile_y_q;
  missile_state_t state_q;

  assign frame_stb = (vga_i.hcount == '0) && (vga_i.vcount == V_ACTIVE);
  assign launch    = frame_stb && (state_q == MS_IDLE) && shoot_i;

  // one step per frame, clamped to the visible width
  always_comb begin
    ship_x_nxt = ship_x_q;
    if (left_i && !right_i) begin
      ship_x_nxt = (ship_x_q < SHIP_STEP) ? '0 : ship_x_q - SHIP_STEP;
    end else if (right_i && !left_i) begin
      ship_x_nxt = (ship_x_q + SHIP_STEP > X_MAX) ? X_MAX : ship_x_q + SHIP_STEP;
    end
  end

  always_ff @(posedge pclk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ship_x_q <= coord_t'(RESET_X_POS);
      state_q  <= MS_IDLE;
    end else if (frame_stb) begin
      ship_x_q <= ship_x_nxt;
      case (state_q)
        MS_IDLE:   if (shoot_i) state_q <= MS_FLYING;
        MS_FLYING: if (missile_y_q < MISSILE_STEP) state_q <= MS_IDLE;
        default:   state_q <= MS_IDLE;
      endcase
    end
  end

  // missile launches from the centre of the new ship position
  always_ff @(posedge pclk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      missile_x_q <= '0;
      missile_y_q <= '0;
    end else if (launch) begin
      missile_x_q <= ship_x_nxt + SHIP_W / 2;
      missile_y_q <= SHIP_Y - MISSILE_H;
    end else if (frame_stb && state_q == MS_FLYING && missile_y_q >= MISSILE_STEP) begin
      missile_y_q <= missile_y_q - MISSILE_STEP;
    end
  end

  assign ship_o.ship_x     = ship_x_q;
  assign ship_o.missile_x  = missile_x_q;
  assign ship_o.missile_y  = missile_y_q;
  assign ship_o.missile_on = (state_q == MS_FLYING);

  a_ship_bounds: assert property (@(posedge pclk) disable iff (!arst_n_i)
    ship_x_q <= X_MAX);

endmodule

/* logic/draw_ship.sv */
/*
 * overlays the player ship and its missile onto the stream,
 * ship colour has priority
 */

`timescale 1ns/1ps

module draw_ship import warblade_pkg::*; #(
  parameter int V_ACTIVE = 48
) (
  input  logic pclk,
  input  logic arst_n_i,
  vga_if.sink   vga_i,
  ship_if.sink  ship_i,
  vga_if.source vga_o
);

  // fixed row, two lines above the bottom border area
  localparam coord_t SHIP_Y = coord_t'(V_ACTIVE - SHIP_H - 2);

  logic active;
  logic in_ship;
  logic in_missile;
  rgb_t rgb_nxt;

  assign active = !vga_i.hblnk && !vga_i.vblnk;

  assign in_ship = (vga_i.hcount >= ship_i.ship_x) &&
                   (vga_i.hcount <  ship_i.ship_x + SHIP_W) &&
                   (vga_i.vcount >= SHIP_Y) &&
                   (vga_i.vcount <  SHIP_Y + SHIP_H);

  assign in_missile = ship_i.missile_on &&
                      (vga_i.hcount == ship_i.missile_x) &&
                      (vga_i.vcount >= ship_i.missile_y) &&
                      (vga_i.vcount <  ship_i.missile_y + MISSILE_H);

  always_comb begin
    rgb_nxt = vga_i.rgb;
    if (active && in_ship) begin
      rgb_nxt = SHIP_COLOR;
    end else if (active && in_missile) begin
      rgb_nxt = MISSILE_COLOR;
    end
  end

  always_ff @(posedge pclk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      vga_o.hcount <= '0;
      vga_o.vcount <= '0;
      vga_o.hsync  <= 1'b0;
      vga_o.vsync  <= 1'b0;
      vga_o.hblnk  <= 1'b0;
      vga_o.vblnk  <= 1'b0;
      vga_o.rgb    <= '0;
    end else begin
      vga_o.hcount <= vga_i.hcount;
      vga_o.vcount <= vga_i.vcount;
      vga_o.hsync  <= vga_i.hsync;
      vga_o.vsync  <= vga_i.vsync;
      vga_o.hblnk  <= vga_i.hblnk;
      vga_o.vblnk  <= vga_i.vblnk;
      vga_o.rgb    <= rgb_nxt;
    end
  end

  // blanking comes from the background stage upstream
  a_blank_black: assert property (@(posedge pclk) disable iff (!arst_n_i)
    (vga_o.hblnk || vga_o.vblnk) |-> (vga_o.rgb == '0));

endmodule

/* logic/warblade_top.sv */
/*
 * top of the pixel path: timing, background, button delay,
 * ship control and ship drawing
 */

`timescale 1ns/1ps

module warblade_top #(
  parameter int H_ACTIVE    = 64,
  parameter int H_FP        = 4,
  parameter int H_SYNC      = 8,
  parameter int H_BP        = 4,
  parameter int V_ACTIVE    = 48,
  parameter int V_FP        = 2,
  parameter int V_SYNC      = 2,
  parameter int V_BP        = 2,
  parameter int RESET_X_POS = 20
) (
  input  logic       pclk,
  input  logic       arst_n_i,
  input  logic       left_i,
  input  logic       right_i,
  input  logic       shoot_i,
  output logic       hs_o,
  output logic       vs_o,
  output logic [3:0] r_o,
  output logic [3:0] g_o,
  output logic [3:0] b_o
);

  vga_if  vga_tim ();
  vga_if  vga_bg ();
  vga_if  vga_out ();
  ship_if ship_pos ();

  logic left_d;
  logic right_d;
  logic shoot_d;

  vga_timing #(
    .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
    .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
  ) vga_timing_inst (
    .pclk(pclk),
    .arst_n_i(arst_n_i),
    .vga_o(vga_tim)
  );

  draw_background #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) draw_background_inst (
    .pclk(pclk),
    .arst_n_i(arst_n_i),
    .vga_i(vga_tim),
    .vga_o(vga_bg)
  );

  // button synchroniser
  delay #(.WIDTH(3), .CLK_DEL(2)) delay_buttons_inst (
    .pclk(pclk),
    .arst_n_i(arst_n_i),
    .din_i({left_i, right_i, shoot_i}),
    .dout_o({left_d, right_d, shoot_d})
  );

  ship_control #(
    .H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE), .RESET_X_POS(RESET_X_POS)
  ) ship_control_inst (
    .pclk(pclk),
    .arst_n_i(arst_n_i),
    .left_i(left_d),
    .right_i(right_d),
    .shoot_i(shoot_d),
    .vga_i(vga_bg),
    .ship_o(ship_pos)
  );

  draw_ship #(.V_ACTIVE(V_ACTIVE)) draw_ship_inst (
    .pclk(pclk),
    .arst_n_i(arst_n_i),
    .vga_i(vga_bg),
    .ship_i(ship_pos),
    .vga_o(vga_out)
  );

  assign hs_o = vga_out.hsync;
  assign vs_o = vga_out.vsync;
  assign r_o  = vga_out.rgb[11:8];
  assign g_o  = vga_out.rgb[7:4];
  assign b_o  = vga_out.rgb[3:0];

endmodule

/* test/tb_warblade_top.sv */
/*
 * testbench for the pixel path: clock and reset, per-frame button
 * patterns, a reference model of the screen and output assertions
 */

`timescale 1ns/1ps

module tb_warblade_top import warblade_pkg::*; ();

  localparam int H_ACTIVE       = 64;
  localparam int H_FP           = 4;
  localparam int H_SYNC         = 8;
  localparam int H_BP           = 4;
  localparam int V_ACTIVE       = 48;
  localparam int V_FP           = 2;
  localparam int V_SYNC         = 2;
  localparam int V_BP           = 2;
  localparam int RESET_X_POS    = 20;
  localparam int H_TOTAL        = H_ACTIVE + H_FP + H_SYNC + H_BP;
  localparam int V_TOTAL        = V_ACTIVE + V_FP + V_SYNC + V_BP;
  localparam int FRAME_CLKS     = H_TOTAL * V_TOTAL;
  // 83 frames of stimulus, two spare, plus reset
  localparam int TIMEOUT_CYCLES = 85 * FRAME_CLKS + 10;
  localparam coord_t SHIP_Y     = coord_t'(V_ACTIVE - SHIP_H - 2);

  logic       pclk, arst_n_i;
  logic       left_i, right_i, shoot_i;
  logic       hs_o, vs_o;
  logic [3:0] r_o, g_o, b_o;

  // model state, pair currently on the DUT outputs
  coord_t     out_h, out_v;
  coord_t     ship_x, missile_x, missile_y;
  logic       missile_on;
  logic [2:0] btn_d1, btn_d2;
  logic       exp_hs, exp_vs;
  rgb_t       exp_rgb;
  int         errors;
  int         cycles;

  warblade_top #(
    .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
    .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP),
    .RESET_X_POS(RESET_X_POS)
  ) warblade_top_inst (.*);

  always #20 pclk = ~pclk;

  // ship column after one frame of movement
  function automatic coord_t moved_x(coord_t x, logic left, logic right);
    if (left && !right) begin
      return (x < SHIP_STEP) ? coord_t'(0) : coord_t'(x - SHIP_STEP);
    end
    if (right && !left) begin
      return (x + SHIP_STEP > H_ACTIVE - SHIP_W) ? coord_t'(H_ACTIVE - SHIP_W)
                                                 : coord_t'(x + SHIP_STEP);
    end
    return x;
  endfunction

  function automatic rgb_t pixel_color(coord_t h, coord_t v, coord_t sx,
                                       coord_t mx, coord_t my, logic mon);
    if (h >= H_ACTIVE || v >= V_ACTIVE) begin
      return '0;
    end
    // ship drawn over missile
    if (h >= sx && h < sx + SHIP_W && v >= SHIP_Y && v < SHIP_Y + SHIP_H) begin
      return SHIP_COLOR;
    end
    if (mon && h == mx && v >= my && v < my + MISSILE_H) begin
      return MISSILE_COLOR;
    end
    if (h == 0 || h == H_ACTIVE - 1 || v == 0 || v == V_ACTIVE - 1) begin
      return BORDER_COLOR;
    end
    return BG_COLOR;
  endfunction

  assign exp_hs  = (out_h >= H_ACTIVE + H_FP) && (out_h < H_ACTIVE + H_FP + H_SYNC);
  assign exp_vs  = (out_v >= V_ACTIVE + V_FP) && (out_v < V_ACTIVE + V_FP + V_SYNC);
  assign exp_rgb = pixel_color(out_h, out_v, ship_x, missile_x, missile_y, missile_on);

  // outputs lag the counters by two cycles, reset pair is two before 0,0
  always @(posedge pclk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_h      <= coord_t'(H_TOTAL - 2);
      out_v      <= coord_t'(V_TOTAL - 1);
      btn_d1     <= '0;
      btn_d2     <= '0;
      ship_x     <= coord_t'(RESET_X_POS);
      missile_x  <= '0;
      missile_y  <= '0;
      missile_on <= 1'b0;
    end else begin
      out_h <= (out_h == H_TOTAL - 1) ? coord_t'(0) : out_h + 1'b1;
      if (out_h == H_TOTAL - 1) begin
        out_v <= (out_v == V_TOTAL - 1) ? coord_t'(0) : out_v + 1'b1;
      end
      btn_d1 <= {left_i, right_i, shoot_i};
      btn_d2 <= btn_d1;
      // frame strobe, the stage ahead of the outputs reaches row V_ACTIVE
      if (out_h == H_TOTAL - 1 && out_v == V_ACTIVE - 1) begin
        ship_x <= moved_x(ship_x, btn_d2[2], btn_d2[1]);
        if (!missile_on && btn_d2[0]) begin
          missile_on <= 1'b1;
          missile_x  <= moved_x(ship_x, btn_d2[2], btn_d2[1]) + SHIP_W / 2;
          missile_y  <= SHIP_Y - MISSILE_H;
        end else if (missile_on && missile_y < MISSILE_STEP) begin
          missile_on <= 1'b0;
        end else if (missile_on) begin
          missile_y <= missile_y - MISSILE_STEP;
        end
      end
    end
  end

  task automatic report_mismatch(string name, int got, int want);
    errors++;
    $display("Error at %0t: %s is %0h, expected %0h", $time, name, got, want);
  endtask

  a_hsync: assert property (@(negedge pclk) disable iff (!arst_n_i) hs_o == exp_hs)
    else report_mismatch("hs_o", hs_o, exp_hs);

  a_vsync: assert property (@(negedge pclk) disable iff (!arst_n_i) vs_o == exp_vs)
    else report_mismatch("vs_o", vs_o, exp_vs);

  a_color: assert property (@(negedge pclk) disable iff (!arst_n_i)
    {r_o, g_o, b_o} == exp_rgb)
    else report_mismatch("rgb", {r_o, g_o, b_o}, exp_rgb);

  always @(posedge pclk) begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
      $display("Result: FAILED");
      $finish;
    end
  end

  // one button pattern, held for whole frames
  task automatic hold_buttons(logic left, logic right, logic shoot, int frames);
    @(posedge pclk);
    #1;
    left_i  = left;
    right_i = right;
    shoot_i = shoot;
    repeat (frames * FRAME_CLKS - 1) @(posedge pclk);
  endtask

  initial begin
    int unsigned pattern;
    pclk     = 1'b0;
    arst_n_i = 1'b0;
    left_i   = 1'b0;
    right_i  = 1'b0;
    shoot_i  = 1'b0;
    errors   = 0;
    cycles   = 0;
    pattern  = $urandom(32'h6f2603c8);
    repeat (10) @(posedge pclk);
    #1;
    arst_n_i = 1'b1;
    hold_buttons(0, 0, 0, 2);
    // right into the clamp at 56, then both held
    hold_buttons(0, 1, 0, 20);
    hold_buttons(1, 1, 0, 2);
    // left into the clamp at 0
    hold_buttons(1, 0, 0, 30);
    hold_buttons(0, 1, 0, 4);
    // launch, shoot kept high through the flight and a relaunch
    hold_buttons(0, 0, 1, 1);
    hold_buttons(0, 0, 1, 12);
    repeat (10) begin
      pattern = $urandom();
      hold_buttons(pattern[2], pattern[1], pattern[0], 1);
    end
    hold_buttons(0, 0, 0, 2);
    $display("Run complete with %0d errors", errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* warblade_top.f */
logic/warblade_pkg.sv
logic/vga_if.sv
logic/ship_if.sv
logic/vga_timing.sv
logic/draw_background.sv
logic/delay.sv
logic/ship_control.sv
logic/draw_ship.sv
logic/warblade_top.sv
test/tb_warblade_top.sv
